//--- flist.f
+incdir+rtl
rtl/tdc_pkg.sv
rtl/uplink_pkg.sv
rtl/shot_timer.sv
rtl/tdc_spi_reader.sv
rtl/sync_fifo.sv
rtl/tdc_channel.sv
rtl/serial_drain.sv
rtl/tof_top.sv
verif/tb_tof_top.sv

//--- rtl/serial_drain.sv
`timescale 1ns/1ps
`default_nettype none

`include "tof_consts.svh"

module serial_drain
  import tdc_pkg::*;
  import uplink_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`NUM_CHANNELS-1:0] not_empty,
  input  tdc_result_t              heads [`NUM_CHANNELS],
  output logic [`NUM_CHANNELS-1:0] pop,
  output logic                     serial_out
);

  localparam int RESULT_BYTES = `RESULT_BITS / 8;
  localparam int IDX_W        = $clog2(RESULT_BYTES);
  localparam int BAUD_W       = (`BAUD_DIV > 1) ? $clog2(`BAUD_DIV) : 1;
  localparam int TXB_W        = $clog2(UART_BITS);

  drain_state_t     state;
  chan_id_t         rr_ptr;
  chan_id_t         sel;
  logic             found;
  tdc_result_t      result_q;
  logic [IDX_W-1:0] byte_idx;

  logic             buf_push;
  byte_t            buf_data;
  logic             buf_pop;
  logic             buf_not_empty;
  byte_t            buf_head;

  logic              tx_busy;
  logic [BAUD_W-1:0] baud_cnt;
  logic [TXB_W-1:0]  tx_bit_cnt;
  logic [UART_BITS-2:0] tx_shift;
  logic              baud_tick;
  logic              tx_last;

  // Round robin, starting after the channel served last
  always_comb begin
    int idx;
    found = 1'b0;
    sel   = '0;
    for (int k = 1; k <= `NUM_CHANNELS; k++) begin
      idx = (int'(rr_ptr) + k) % `NUM_CHANNELS;
      if (!found && not_empty[idx]) begin
        found = 1'b1;
        sel   = chan_id_t'(idx);
      end
    end
  end

  always_comb begin
    pop = '0;
    if (state == DRAIN_SELECT && found) begin
      pop[sel] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= DRAIN_IDLE;
      rr_ptr   <= chan_id_t'(`NUM_CHANNELS - 1);
      byte_idx <= '0;
    end else begin
      case (state)
        DRAIN_IDLE: begin
          if (!buf_not_empty && !tx_busy) begin
            state <= DRAIN_SELECT;
          end
        end
        DRAIN_SELECT: begin
          if (found) begin
            state  <= DRAIN_SEND_ID;
            rr_ptr <= sel;
          end
        end
        DRAIN_SEND_ID: begin
          state    <= DRAIN_SEND_RESULT;
          byte_idx <= '0;
        end
        default: begin
          if (byte_idx == IDX_W'(RESULT_BYTES - 1)) begin
            state <= DRAIN_IDLE;
          end else begin
            byte_idx <= byte_idx + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == DRAIN_SELECT && found) begin
      result_q <= heads[sel];
    end
  end

  // Id byte, then result bytes MSB first
  assign buf_push = (state == DRAIN_SEND_ID) || (state == DRAIN_SEND_RESULT);

  always_comb begin
    if (state == DRAIN_SEND_ID) begin
      buf_data = byte_t'(rr_ptr);
    end else begin
      buf_data = byte_t'(result_q >> (8 * (RESULT_BYTES - 1 - int'(byte_idx))));
    end
  end

  sync_fifo #(
    .payload_t (byte_t),
    .depth     (FRAME_BYTES)
  ) i_frame_buf (
    .clk       (clk),
    .rst       (rst),
    .push      (buf_push),
    .push_data (buf_data),
    .pop       (buf_pop),
    .not_empty (buf_not_empty),
    .head      (buf_head)
  );

  assign baud_tick = (baud_cnt == BAUD_W'(`BAUD_DIV - 1));
  assign tx_last   = tx_busy && baud_tick && (tx_bit_cnt == TXB_W'(UART_BITS - 1));
  // Next byte loads on the last stop bit cycle so bytes run back to back
  assign buf_pop   = buf_not_empty && (!tx_busy || tx_last);

  always_ff @(posedge clk) begin
    if (rst) begin
      tx_busy    <= 1'b0;
      serial_out <= 1'b1;
      baud_cnt   <= '0;
      tx_bit_cnt <= '0;
    end else if (buf_pop) begin
      tx_busy    <= 1'b1;
      serial_out <= 1'b0;
      baud_cnt   <= '0;
      tx_bit_cnt <= '0;
    end else if (tx_busy) begin
      if (baud_tick) begin
        baud_cnt <= '0;
        if (tx_bit_cnt == TXB_W'(UART_BITS - 1)) begin
          tx_busy <= 1'b0;
        end else begin
          serial_out <= tx_shift[0];
          tx_bit_cnt <= tx_bit_cnt + 1'b1;
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // Data LSB first, stop bit at the top
  always_ff @(posedge clk) begin
    if (buf_pop) begin
      tx_shift <= {1'b1, buf_head};
    end else if (tx_busy && baud_tick) begin
      tx_shift <= {1'b1, tx_shift[UART_BITS-2:1]};
    end
  end

endmodule

`default_nettype wire

//--- rtl/shot_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "tof_consts.svh"

module shot_timer (
  input  logic clk,
  input  logic rst,
  input  logic pause,
  output logic shot
);

  localparam int CNT_W = $clog2(`SHOT_PERIOD);

  logic [CNT_W-1:0] count;

  // Wrap at the shot period, frozen while paused
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
      shot  <= 1'b0;
    end else begin
      shot <= 1'b0;
      if (!pause) begin
        if (count == CNT_W'(`SHOT_PERIOD - 1)) begin
          count <= '0;
          shot  <= 1'b1;
        end else begin
          count <= count + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "tof_consts.svh"

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = `FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output logic     not_empty,
  output payload_t head
);

  localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
  localparam int CNT_W = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // New data is dropped when full
  assign do_push   = push && (count != CNT_W'(depth));
  assign do_pop    = pop && not_empty;
  assign not_empty = (count != '0);
  assign head      = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

`default_nettype wire

//--- rtl/tdc_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "tof_consts.svh"

module tdc_channel
  import tdc_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        shot,
  input  logic        enable,
  input  logic        intb,
  input  logic        dout,
  output logic        start_signal,
  output logic        cs,
  output logic        sck,
  output logic        mosi,
  input  logic        pop,
  output logic        not_empty,
  output tdc_result_t head
);

  localparam int START_W = (`START_WIDTH > 1) ? $clog2(`START_WIDTH) : 1;

  typedef enum logic [1:0] {
    CH_IDLE,
    CH_START,
    CH_WAIT,
    CH_READ
  } chan_state_t;

  chan_state_t        state;
  logic [START_W-1:0] start_cnt;
  logic               intb_meta;
  logic               intb_sync;
  logic               go;
  logic               done;
  tdc_result_t        result;

  // TDC interrupt is asynchronous to clk
  always_ff @(posedge clk) begin
    if (rst) begin
      intb_meta <= 1'b1;
      intb_sync <= 1'b1;
    end else begin
      intb_meta <= intb;
      intb_sync <= intb_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= CH_IDLE;
      start_signal <= 1'b0;
      start_cnt    <= '0;
      go           <= 1'b0;
    end else begin
      go <= 1'b0;
      case (state)
        CH_IDLE: begin
          if (shot && enable) begin
            state        <= CH_START;
            start_signal <= 1'b1;
            start_cnt    <= '0;
          end
        end
        CH_START: begin
          if (start_cnt == START_W'(`START_WIDTH - 1)) begin
            state        <= CH_WAIT;
            start_signal <= 1'b0;
          end else begin
            start_cnt <= start_cnt + 1'b1;
          end
        end
        CH_WAIT: begin
          // Stop flight measured, fetch the result
          if (!intb_sync) begin
            state <= CH_READ;
            go    <= 1'b1;
          end
        end
        default: begin
          if (done) begin
            state <= CH_IDLE;
          end
        end
      endcase
    end
  end

  tdc_spi_reader i_reader (
    .clk    (clk),
    .rst    (rst),
    .go     (go),
    .dout   (dout),
    .cs     (cs),
    .sck    (sck),
    .mosi   (mosi),
    .done   (done),
    .result (result)
  );

  sync_fifo #(
    .payload_t (tdc_result_t),
    .depth     (`FIFO_DEPTH)
  ) i_result_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (done),
    .push_data (result),
    .pop       (pop),
    .not_empty (not_empty),
    .head      (head)
  );

endmodule

`default_nettype wire

//--- rtl/tdc_pkg.sv
`default_nettype none

`include "tof_consts.svh"

package tdc_pkg;

  // Time-of-flight count as read from the TDC
  typedef logic [`RESULT_BITS-1:0] tdc_result_t;

  // Channel index, wide enough for six channels
  typedef logic [2:0] chan_id_t;

endpackage

`default_nettype wire

//--- rtl/tdc_spi_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "tof_consts.svh"

module tdc_spi_reader
  import tdc_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        go,
  input  logic        dout,
  output logic        cs,
  output logic        sck,
  output logic        mosi,
  output logic        done,
  output tdc_result_t result
);

  // Opcode byte followed by the result word
  localparam int FRAME_BITS = 8 + `RESULT_BITS;
  localparam int BIT_W      = $clog2(FRAME_BITS);
  localparam int DIV_W      = (`SPI_DIV > 1) ? $clog2(`SPI_DIV) : 1;

  logic                  busy;
  logic [DIV_W-1:0]      div_cnt;
  logic [BIT_W-1:0]      bit_cnt;
  logic [FRAME_BITS-1:0] shift_reg;
  logic                  half_tick;

  assign half_tick = (div_cnt == DIV_W'(`SPI_DIV - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      cs      <= 1'b1;
      sck     <= 1'b0;
      mosi    <= 1'b0;
      done    <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        if (go) begin
          busy    <= 1'b1;
          cs      <= 1'b0;
          div_cnt <= '0;
          bit_cnt <= '0;
          // Opcode MSB is set up before the first rising edge
          mosi    <= 1'(`TDC_READ_OPCODE >> 7);
        end
      end else if (half_tick) begin
        div_cnt <= '0;
        sck     <= ~sck;
        if (sck) begin
          // Falling edge ends one SCK period
          if (bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
            busy <= 1'b0;
            cs   <= 1'b1;
            mosi <= 1'b0;
            done <= 1'b1;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
            // Opcode bits first, then hold mosi low while the result comes in
            mosi    <= (bit_cnt < BIT_W'(7)) ? shift_reg[FRAME_BITS-1] : 1'b0;
          end
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // Opcode leaves from the top while dout fills from the bottom
  always_ff @(posedge clk) begin
    if (!busy && go) begin
      shift_reg <= {`TDC_READ_OPCODE, {`RESULT_BITS{1'b0}}};
    end else if (busy && half_tick && !sck) begin
      shift_reg <= {shift_reg[FRAME_BITS-2:0], dout};
    end
  end

  always_ff @(posedge clk) begin
    if (busy && half_tick && sck && bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
      result <= shift_reg[`RESULT_BITS-1:0];
    end
  end

endmodule

`default_nettype wire

//--- rtl/tof_consts.svh
`ifndef TOF_CONSTS_SVH
`define TOF_CONSTS_SVH

// Channel count
`define NUM_CHANNELS 6

// Shot rate in clock cycles
`define SHOT_PERIOD 1200

// Laser start pulse length
`define START_WIDTH 4

// TDC SPI clock divider, cycles per SCK half period
`define SPI_DIV 2

// Uplink cycles per UART bit
`define BAUD_DIV 4

`define RESULT_BITS 24

// Read command for the TDC result register
`define TDC_READ_OPCODE 8'h8C

`define FIFO_DEPTH 4

`endif

//--- rtl/tof_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "tof_consts.svh"

module tof_top
  import tdc_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     pause,
  input  logic [`NUM_CHANNELS-1:0] enable,
  input  logic [`NUM_CHANNELS-1:0] intb,
  input  logic [`NUM_CHANNELS-1:0] dout,
  output logic [`NUM_CHANNELS-1:0] start_signal,
  output logic [`NUM_CHANNELS-1:0] cs,
  output logic [`NUM_CHANNELS-1:0] sck,
  output logic [`NUM_CHANNELS-1:0] mosi,
  output logic                     serial_out
);

  logic                     shot;
  logic [`NUM_CHANNELS-1:0] not_empty;
  logic [`NUM_CHANNELS-1:0] pop;
  tdc_result_t              heads [`NUM_CHANNELS];

  shot_timer i_shot_timer (
    .clk   (clk),
    .rst   (rst),
    .pause (pause),
    .shot  (shot)
  );

  // One TDC readout path per laser channel
  for (genvar i = 0; i < `NUM_CHANNELS; i++) begin : g_chan
    tdc_channel i_channel (
      .clk          (clk),
      .rst          (rst),
      .shot         (shot),
      .enable       (enable[i]),
      .intb         (intb[i]),
      .dout         (dout[i]),
      .start_signal (start_signal[i]),
      .cs           (cs[i]),
      .sck          (sck[i]),
      .mosi         (mosi[i]),
      .pop          (pop[i]),
      .not_empty    (not_empty[i]),
      .head         (heads[i])
    );
  end

  serial_drain i_drain (
    .clk        (clk),
    .rst        (rst),
    .not_empty  (not_empty),
    .heads      (heads),
    .pop        (pop),
    .serial_out (serial_out)
  );

endmodule

`default_nettype wire

//--- rtl/uplink_pkg.sv
`default_nettype none

package uplink_pkg;

  typedef logic [7:0] byte_t;

  // Id byte plus three result bytes
  localparam int FRAME_BYTES = 4;

  // Start, eight data bits, stop
  localparam int UART_BITS = 10;

  // Drain phases
  typedef enum logic [1:0] {
    DRAIN_IDLE,
    DRAIN_SELECT,
    DRAIN_SEND_ID,
    DRAIN_SEND_RESULT
  } drain_state_t;

endpackage

`default_nettype wire

//--- verif/tb_tof_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "tof_consts.svh"

module tb_tof_top
  import tdc_pkg::*;
  import uplink_pkg::*;
();

  localparam int N              = `NUM_CHANNELS;
  localparam int TOTAL_SHOTS    = 10 + 6 + 3;
  localparam int PAUSE_SHOTS    = 3;
  localparam int TIMEOUT_CYCLES = (TOTAL_SHOTS + PAUSE_SHOTS) * `SHOT_PERIOD + 2000;

  logic         clk;
  logic         rst;
  logic         pause;
  logic [N-1:0] enable;
  logic [N-1:0] intb;
  logic [N-1:0] dout;
  logic [N-1:0] start_signal;
  logic [N-1:0] cs;
  logic [N-1:0] sck;
  logic [N-1:0] mosi;
  logic         serial_out;

  // TDC pin models
  integer       seed;
  logic [N-1:0] intb_nxt;
  logic [N-1:0] dout_nxt;
  logic [N-1:0] prev_start;
  logic [N-1:0] prev_cs;
  logic [N-1:0] prev_sck;
  logic [N-1:0] waiting;
  logic [N-1:0] reading;
  int           wait_cnt  [N];
  int           fall_cnt  [N];
  int           rise_cnt  [N];
  byte_t        op_bits   [N];
  tdc_result_t  tof_value [N];
  int           last_rise [N];
  tdc_result_t  exp_q     [N][$];

  // UART receiver
  logic         rx_busy;
  int           rx_cnt;
  byte_t        rx_byte;
  byte_t        rx_frame [FRAME_BYTES];
  int           rx_nbytes;

  // Test control and scoreboard
  int           cycle;
  int           shot_cnt;
  int           readouts;
  int           frames;
  int           checks;
  int           test_err [1:6];
  int           data_test;
  logic         spacing_on;
  logic         in_pause;
  logic [N-1:0] dis_mask;

  tof_top i_dut (
    .clk          (clk),
    .rst          (rst),
    .pause        (pause),
    .enable       (enable),
    .intb         (intb),
    .dout         (dout),
    .start_signal (start_signal),
    .cs           (cs),
    .sck          (sck),
    .mosi         (mosi),
    .serial_out   (serial_out)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_bits(input string name, input logic [N-1:0] got,
                            input logic [N-1:0] exp, input int test);
    checks++;
    if (got !== exp) begin
      $display("ERR t=%0t %s: got %b expected %b", $time, name, got, exp);
      test_err[test]++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp, input int test);
    checks++;
    if (got != exp) begin
      $display("ERR t=%0t %s: got %0d expected %0d", $time, name, got, exp);
      test_err[test]++;
    end
  endtask

  task automatic check_chan(input string name, input chan_id_t got, input chan_id_t exp,
                            input int test);
    checks++;
    if (got !== exp) begin
      $display("ERR t=%0t %s: got %0d expected %0d", $time, name, got, exp);
      test_err[test]++;
    end
  endtask

  task automatic check_result(input string name, input tdc_result_t got,
                              input tdc_result_t exp, input int test);
    checks++;
    if (got !== exp) begin
      $display("ERR t=%0t %s: got %h expected %h", $time, name, got, exp);
      test_err[test]++;
    end
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp,
                            input int test);
    checks++;
    if (got !== exp) begin
      $display("ERR t=%0t %s: got %h expected %h", $time, name, got, exp);
      test_err[test]++;
    end
  endtask

  // Match the received frame against the pending readouts
  task automatic score_frame();
    byte_t       id;
    tdc_result_t got_res;
    int          match;
    id      = rx_frame[0];
    got_res = {rx_frame[1], rx_frame[2], rx_frame[3]};
    frames++;
    if (id >= byte_t'(N)) begin
      $display("Frame at t=%0t carries id %0d, which names no channel", $time, id);
      test_err[data_test]++;
    end else begin
      if (dis_mask[id]) begin
        $display("Frame at t=%0t comes from disabled channel %0d", $time, id);
        test_err[5]++;
      end
      match = int'(id);
      if (exp_q[id].size() == 0 || exp_q[id][0] !== got_res) begin
        for (int k = N - 1; k >= 0; k--) begin
          if (exp_q[k].size() > 0 && exp_q[k][0] === got_res) match = k;
        end
      end
      check_chan("frame id", chan_id_t'(id), chan_id_t'(match), data_test);
      if (exp_q[id].size() == 0) begin
        $display("Frame at t=%0t for channel %0d has no readout pending", $time, id);
        test_err[data_test]++;
      end else begin
        check_result("frame result", got_res, exp_q[id].pop_front(), data_test);
      end
    end
  endtask

  // 8N1, sampled in the middle of each bit
  task automatic uart_step();
    int bit_idx;
    if (!rx_busy) begin
      if (!serial_out) begin
        rx_busy = 1'b1;
        rx_cnt  = 0;
      end
    end else begin
      rx_cnt++;
      if (rx_cnt % `BAUD_DIV == `BAUD_DIV / 2) begin
        bit_idx = rx_cnt / `BAUD_DIV;
        if (bit_idx == 0) begin
          if (serial_out) begin
            $display("Start bit on serial_out at t=%0t was too short", $time);
            test_err[data_test]++;
            rx_busy = 1'b0;
          end
        end else if (bit_idx <= 8) begin
          rx_byte[bit_idx-1] = serial_out;
        end else begin
          rx_busy = 1'b0;
          if (!serial_out) begin
            $display("Stop bit on serial_out at t=%0t was low", $time);
            test_err[data_test]++;
          end else begin
            rx_frame[rx_nbytes] = rx_byte;
            rx_nbytes++;
            if (rx_nbytes == FRAME_BYTES) begin
              score_frame();
              rx_nbytes = 0;
            end
          end
        end
      end
    end
  endtask

  task automatic tdc_step(input int ch);
    if (start_signal[ch] && !prev_start[ch]) begin
      if (dis_mask[ch]) begin
        $display("Channel %0d raised start_signal at t=%0t while disabled", ch, $time);
        test_err[5]++;
      end
      if (in_pause) begin
        $display("Channel %0d raised start_signal at t=%0t during pause", ch, $time);
        test_err[6]++;
      end
      if (spacing_on && last_rise[ch] >= 0) begin
        check_count("start spacing", cycle - last_rise[ch], `SHOT_PERIOD, 4);
      end
      last_rise[ch] = cycle;
      tof_value[ch] = tdc_result_t'($random(seed));
      wait_cnt[ch]  = 5 + {$random(seed)} % 36;
      waiting[ch]   = 1'b1;
    end
    if (waiting[ch]) begin
      if (wait_cnt[ch] > 0) begin
        wait_cnt[ch]--;
      end else begin
        intb_nxt[ch] = 1'b0;
      end
    end
    if (!cs[ch] && prev_cs[ch]) begin
      intb_nxt[ch] = 1'b1;
      waiting[ch]  = 1'b0;
      reading[ch]  = 1'b1;
      fall_cnt[ch] = 0;
      rise_cnt[ch] = 0;
      op_bits[ch]  = '0;
      dout_nxt[ch] = 1'b0;
    end
    if (reading[ch] && !cs[ch]) begin
      if (sck[ch] && !prev_sck[ch]) begin
        rise_cnt[ch]++;
        if (rise_cnt[ch] <= 8) op_bits[ch] = {op_bits[ch][6:0], mosi[ch]};
      end
      // Result bits follow the command byte
      if (!sck[ch] && prev_sck[ch]) begin
        fall_cnt[ch]++;
        if (fall_cnt[ch] >= 8 && fall_cnt[ch] <= 31) begin
          dout_nxt[ch] = tof_value[ch][31-fall_cnt[ch]];
        end
      end
    end
    if (reading[ch] && cs[ch] && !prev_cs[ch]) begin
      check_byte("mosi opcode", op_bits[ch], `TDC_READ_OPCODE, 3);
      exp_q[ch].push_back(tof_value[ch]);
      reading[ch]  = 1'b0;
      dout_nxt[ch] = 1'b0;
      readouts++;
    end
  endtask

  // Sample 1 ns after the edge, drive the TDC pins at 2 ns
  always @(posedge clk) begin
    #1;
    cycle++;
    for (int ch = 0; ch < N; ch++) begin
      tdc_step(ch);
    end
    if ((start_signal & ~prev_start) != '0) shot_cnt++;
    uart_step();
    prev_start = start_signal;
    prev_cs    = cs;
    prev_sck   = sck;
    #1;
    intb = intb_nxt;
    dout = dout_nxt;
  end

  task automatic step_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic wait_shots(input int n);
    int target;
    target = shot_cnt + n;
    while (shot_cnt < target) step_cycle();
  endtask

  function automatic bit all_drained();
    bit idle;
    idle = !rx_busy && rx_nbytes == 0 && waiting == '0 && reading == '0;
    for (int k = 0; k < N; k++) begin
      if (exp_q[k].size() != 0) idle = 1'b0;
    end
    return idle;
  endfunction

  task automatic wait_drained();
    step_cycle();
    while (!all_drained()) step_cycle();
  endtask

  task automatic check_levels();
    check_bits("start_signal", start_signal, '0, 1);
    check_bits("cs", cs, '1, 1);
    check_bits("sck", sck, '0, 1);
    check_bits("mosi", mosi, '0, 1);
    check_bits("serial_out", {{(N-1){1'b0}}, serial_out}, 1, 1);
  endtask

  task automatic report_test(input int n, input string name);
    $display("Test %0d %s: %s, %0d error(s)", n, name,
             (test_err[n] == 0) ? "pass" : "fail", test_err[n]);
  endtask

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Run stopped after %0d cycles without reaching the end of the tests",
             TIMEOUT_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    int          frames_start;
    int          n_off;
    int          k;
    int          total_err;
    logic [N-1:0] mask;
    rst        = 1'b1;
    pause      = 1'b0;
    enable     = '1;
    intb       = '1;
    dout       = '0;
    seed       = 41;
    intb_nxt   = '1;
    dout_nxt   = '0;
    prev_start = '0;
    prev_cs    = '1;
    prev_sck   = '0;
    waiting    = '0;
    reading    = '0;
    rx_busy    = 1'b0;
    rx_cnt     = 0;
    rx_nbytes  = 0;
    cycle      = 0;
    shot_cnt   = 0;
    readouts   = 0;
    frames     = 0;
    checks     = 0;
    data_test  = 2;
    spacing_on = 1'b0;
    in_pause   = 1'b0;
    dis_mask   = '0;
    for (int i = 0; i < N; i++) last_rise[i] = -1;
    for (int i = 1; i <= 6; i++) test_err[i] = 0;

    for (int i = 0; i < 5; i++) begin
      step_cycle();
      check_levels();
    end
    rst = 1'b0;
    step_cycle();
    check_levels();
    report_test(1, "reset levels");

    // All channels for ten shots
    spacing_on   = 1'b1;
    frames_start = frames;
    wait_shots(10);
    wait_drained();
    spacing_on   = 1'b0;
    check_count("frames", frames - frames_start, 10 * N, 2);
    report_test(2, "data path");
    if (readouts == 0) begin
      $display("No TDC readout took place");
      test_err[3]++;
    end
    report_test(3, "opcode");
    report_test(4, "shot spacing");

    // Random half of the channels off
    mask  = '0;
    n_off = 0;
    while (n_off < N / 2) begin
      k = {$random(seed)} % N;
      if (!mask[k]) begin
        mask[k] = 1'b1;
        n_off++;
      end
    end
    data_test    = 5;
    enable       = ~mask;
    dis_mask     = mask;
    frames_start = frames;
    wait_shots(6);
    wait_drained();
    check_count("frames", frames - frames_start, 6 * (N - N / 2), 5);
    enable   = '1;
    dis_mask = '0;
    report_test(5, "enable");

    // A shot already in flight may still start on the next cycle
    data_test = 6;
    pause     = 1'b1;
    step_cycle();
    step_cycle();
    in_pause  = 1'b1;
    repeat (PAUSE_SHOTS * `SHOT_PERIOD - 2) step_cycle();
    in_pause     = 1'b0;
    pause        = 1'b0;
    frames_start = frames;
    wait_shots(3);
    wait_drained();
    check_count("frames", frames - frames_start, 3 * N, 6);
    report_test(6, "pause");

    total_err = 0;
    for (int i = 1; i <= 6; i++) total_err += test_err[i];
    $display("Checks %0d, errors %0d, frames %0d, readouts %0d",
             checks, total_err, frames, readouts);
    if (total_err == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
